// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mc_core
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  riscv_pkg::word_t   a,
  input  riscv_pkg::word_t   b,
  input  riscv_pkg::alu_op_e op,
  output riscv_pkg::word_t   result,
  output logic               zero
);

  always_comb begin
    case (op)
      riscv_pkg::alu_add: result = a + b;
      riscv_pkg::alu_sub: result = a - b;
      riscv_pkg::alu_and: result = a & b;
      riscv_pkg::alu_or:  result = a | b;
      riscv_pkg::alu_xor: result = a ^ b;
      // signed compare.
      riscv_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
      default:            result = '0;
    endcase
  end

  // beq looks at this after a sub.
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  riscv_pkg::opcode_e opcode,
  input  logic               zero,
  output riscv_pkg::ctrl_t   ctrl,
  output logic               retire_pulse,
  output logic               halted
);

  riscv_pkg::fsm_state_e state;
  riscv_pkg::fsm_state_e state_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= riscv_pkg::st_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = riscv_pkg::st_fetch;
    case (state)
      riscv_pkg::st_fetch: state_next = riscv_pkg::st_decode;
      riscv_pkg::st_decode: begin
        case (opcode)
          riscv_pkg::opc_op:     state_next = riscv_pkg::st_exec_r;
          riscv_pkg::opc_op_imm: state_next = riscv_pkg::st_exec_i;
          riscv_pkg::opc_load:   state_next = riscv_pkg::st_mem_addr;
          riscv_pkg::opc_store:  state_next = riscv_pkg::st_mem_addr;
          riscv_pkg::opc_branch: state_next = riscv_pkg::st_branch;
          riscv_pkg::opc_jal:    state_next = riscv_pkg::st_jal;
          default:               state_next = riscv_pkg::st_halt;
        endcase
      end
      riscv_pkg::st_mem_addr: begin
        if (opcode == riscv_pkg::opc_load) begin
          state_next = riscv_pkg::st_mem_read;
        end else begin
          state_next = riscv_pkg::st_mem_write;
        end
      end
      riscv_pkg::st_mem_read: state_next = riscv_pkg::st_mem_wb;
      riscv_pkg::st_exec_r:   state_next = riscv_pkg::st_alu_wb;
      riscv_pkg::st_exec_i:   state_next = riscv_pkg::st_alu_wb;
      // only reset leaves halt.
      riscv_pkg::st_halt:     state_next = riscv_pkg::st_halt;
      default:                state_next = riscv_pkg::st_fetch;
    endcase
  end

  always_comb begin
    ctrl = '0;
    retire_pulse = 1'b0;
    case (state)
      riscv_pkg::st_fetch: begin
        ctrl.ir_write    = 1'b1;
        ctrl.pc_update   = 1'b1;
        ctrl.adr_src     = riscv_pkg::adr_pc;
        ctrl.alu_src_a   = riscv_pkg::src_a_pc;
        ctrl.alu_src_b   = riscv_pkg::src_b_four;
        ctrl.alu_sel_add = 1'b1;
        ctrl.pc_src      = riscv_pkg::pc_alu_result;
      end
      riscv_pkg::st_decode: begin
        // branch and jump target lands in alu_out.
        ctrl.alu_src_a   = riscv_pkg::src_a_old_pc;
        ctrl.alu_src_b   = riscv_pkg::src_b_imm;
        ctrl.alu_sel_add = 1'b1;
      end
      riscv_pkg::st_mem_addr: begin
        ctrl.alu_src_a   = riscv_pkg::src_a_reg;
        ctrl.alu_src_b   = riscv_pkg::src_b_imm;
        ctrl.alu_sel_add = 1'b1;
      end
      riscv_pkg::st_mem_read: begin
        ctrl.adr_src    = riscv_pkg::adr_result;
        ctrl.result_src = riscv_pkg::res_alu_out;
      end
      riscv_pkg::st_mem_wb: begin
        ctrl.result_src = riscv_pkg::res_data;
        ctrl.reg_write  = 1'b1;
        retire_pulse    = 1'b1;
      end
      riscv_pkg::st_mem_write: begin
        ctrl.adr_src    = riscv_pkg::adr_result;
        ctrl.result_src = riscv_pkg::res_alu_out;
        ctrl.mem_write  = 1'b1;
        retire_pulse    = 1'b1;
      end
      riscv_pkg::st_exec_r: begin
        ctrl.alu_src_a = riscv_pkg::src_a_reg;
        ctrl.alu_src_b = riscv_pkg::src_b_reg;
      end
      riscv_pkg::st_exec_i: begin
        ctrl.alu_src_a = riscv_pkg::src_a_reg;
        ctrl.alu_src_b = riscv_pkg::src_b_imm;
      end
      riscv_pkg::st_alu_wb: begin
        ctrl.result_src = riscv_pkg::res_alu_out;
        ctrl.reg_write  = 1'b1;
        retire_pulse    = 1'b1;
      end
      riscv_pkg::st_branch: begin
        ctrl.alu_src_a = riscv_pkg::src_a_reg;
        ctrl.alu_src_b = riscv_pkg::src_b_reg;
        ctrl.pc_src    = riscv_pkg::pc_alu_out;
        ctrl.pc_update = zero;
        retire_pulse   = 1'b1;
      end
      riscv_pkg::st_jal: begin
        // link value is old pc plus 4, target comes from decode.
        ctrl.alu_src_a   = riscv_pkg::src_a_old_pc;
        ctrl.alu_src_b   = riscv_pkg::src_b_four;
        ctrl.alu_sel_add = 1'b1;
        ctrl.result_src  = riscv_pkg::res_alu_result;
        ctrl.reg_write   = 1'b1;
        ctrl.pc_src      = riscv_pkg::pc_alu_out;
        ctrl.pc_update   = 1'b1;
        retire_pulse     = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  assign halted = (state == riscv_pkg::st_halt);

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  riscv_pkg::ctrl_t ctrl,
  input  riscv_pkg::word_t alu_result,
  input  riscv_pkg::word_t alu_out,
  input  riscv_pkg::word_t mem_rdata,
  output riscv_pkg::word_t pc,
  output riscv_pkg::word_t pc_old,
  output riscv_pkg::word_t instr
);

  riscv_pkg::word_t pc_next;

  assign pc_next = (ctrl.pc_src == riscv_pkg::pc_alu_result) ? alu_result : alu_out;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= '0;
      pc_old <= '0;
    end else begin
      if (ctrl.pc_update) begin
        pc <= pc_next;
      end
      if (ctrl.ir_write) begin
        pc_old <= pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      instr <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
riscv_pkg.sv
alu.sv
reg_file.sv
instr_decode.sv
control_fsm.sv
unified_mem.sv
fetch_unit.sv
mc_core.sv
tb_mc_core.sv

// File: instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  riscv_pkg::word_t   instr,
  output riscv_pkg::opcode_e opcode,
  output logic [4:0]         rd,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output riscv_pkg::alu_op_e alu_op,
  output riscv_pkg::word_t   imm_ext
);

  logic [2:0] funct3;

  // unknown opcodes pass through raw.
  assign opcode = riscv_pkg::opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];

  always_comb begin
    alu_op = riscv_pkg::alu_add;
    if (opcode == riscv_pkg::opc_op || opcode == riscv_pkg::opc_op_imm) begin
      case (funct3)
        3'b000: begin
          // funct7 bit 5 only selects sub for register operands.
          if (opcode == riscv_pkg::opc_op && instr[30]) begin
            alu_op = riscv_pkg::alu_sub;
          end
        end
        3'b010:  alu_op = riscv_pkg::alu_slt;
        3'b100:  alu_op = riscv_pkg::alu_xor;
        3'b110:  alu_op = riscv_pkg::alu_or;
        3'b111:  alu_op = riscv_pkg::alu_and;
        default: alu_op = riscv_pkg::alu_add;
      endcase
    end else if (opcode == riscv_pkg::opc_branch) begin
      alu_op = riscv_pkg::alu_sub;
    end
  end

  always_comb begin
    case (opcode)
      riscv_pkg::opc_store:
        imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      riscv_pkg::opc_branch:
        imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      riscv_pkg::opc_jal:
        imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm_ext = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// File: mc_core.sv
`timescale 1ns/1ns
`default_nettype none

module mc_core #(
  parameter int mem_words = 1024
) (
  input  logic               clk,
  input  logic               rst_n,
  input  riscv_pkg::load_t   load,
  output riscv_pkg::retire_t retire,
  output logic               halted
);

  riscv_pkg::ctrl_t   ctrl;
  riscv_pkg::opcode_e opcode;
  riscv_pkg::alu_op_e dec_alu_op;
  riscv_pkg::alu_op_e alu_op;
  logic               retire_pulse;
  logic               zero;
  logic [4:0]         rd;
  logic [4:0]         rs1;
  logic [4:0]         rs2;
  riscv_pkg::word_t   pc, pc_old, instr, imm_ext;
  riscv_pkg::word_t   mem_addr, mem_rdata;
  riscv_pkg::word_t   rd1, rd2, data_a, data_b, data_reg;
  riscv_pkg::word_t   alu_a, alu_b, alu_result, alu_out, result;

  control_fsm control_fsm_i (.clk(clk), .rst_n(rst_n), .opcode(opcode), .zero(zero),
                             .ctrl(ctrl), .retire_pulse(retire_pulse), .halted(halted));

  fetch_unit fetch_unit_i (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .alu_result(alu_result),
                           .alu_out(alu_out), .mem_rdata(mem_rdata), .pc(pc),
                           .pc_old(pc_old), .instr(instr));

  assign mem_addr = (ctrl.adr_src == riscv_pkg::adr_pc) ? pc : result;

  unified_mem #(.mem_words(mem_words)) unified_mem_i (
    .clk(clk), .addr(mem_addr), .wdata(data_b), .write(ctrl.mem_write), .load(load),
    .rdata(mem_rdata));

  instr_decode instr_decode_i (.instr(instr), .opcode(opcode), .rd(rd), .rs1(rs1),
                               .rs2(rs2), .alu_op(dec_alu_op), .imm_ext(imm_ext));

  reg_file reg_file_i (.clk(clk), .rst_n(rst_n), .addr1(rs1), .addr2(rs2), .addr3(rd),
                       .write(ctrl.reg_write), .data_in(result), .rd1(rd1), .rd2(rd2));

  assign alu_op = ctrl.alu_sel_add ? riscv_pkg::alu_add : dec_alu_op;

  alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero));

  // registers between cycles.
  always_ff @(posedge clk) begin
    data_a   <= rd1;
    data_b   <= rd2;
    data_reg <= mem_rdata;
    alu_out  <= alu_result;
  end

  always_comb begin
    case (ctrl.alu_src_a)
      riscv_pkg::src_a_pc:     alu_a = pc;
      riscv_pkg::src_a_old_pc: alu_a = pc_old;
      default:                 alu_a = data_a;
    endcase
    case (ctrl.alu_src_b)
      riscv_pkg::src_b_imm:  alu_b = imm_ext;
      riscv_pkg::src_b_four: alu_b = 32'd4;
      default:               alu_b = data_b;
    endcase
    case (ctrl.result_src)
      riscv_pkg::res_data:       result = data_reg;
      riscv_pkg::res_alu_result: result = alu_result;
      default:                   result = alu_out;
    endcase
  end

  // fields of writes that did not happen read as zero.
  always_comb begin
    retire.valid      = retire_pulse;
    retire.pc         = pc_old;
    retire.rd_write   = ctrl.reg_write;
    retire.rd         = ctrl.reg_write ? rd : 5'd0;
    retire.rd_value   = ctrl.reg_write ? result : '0;
    retire.store      = ctrl.mem_write;
    retire.store_addr = ctrl.mem_write ? mem_addr : '0;
    retire.store_data = ctrl.mem_write ? data_b : '0;
  end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       addr1,
  input  logic [4:0]       addr2,
  input  logic [4:0]       addr3,
  input  logic             write,
  input  riscv_pkg::word_t data_in,
  output riscv_pkg::word_t rd1,
  output riscv_pkg::word_t rd2
);

  riscv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write && addr3 != 5'd0) begin
      regs[addr3] <= data_in;
    end
  end

  // x0 reads as zero.
  assign rd1 = (addr1 == 5'd0) ? '0 : regs[addr1];
  assign rd2 = (addr2 == 5'd0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  typedef logic [31:0] word_t;

  // major opcodes of the supported subset.
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef enum logic [3:0] {
    st_fetch,
    st_decode,
    st_mem_addr,
    st_mem_read,
    st_mem_wb,
    st_mem_write,
    st_exec_r,
    st_exec_i,
    st_alu_wb,
    st_branch,
    st_jal,
    st_halt
  } fsm_state_e;

  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_reg} alu_src_a_e;
  typedef enum logic [1:0] {src_b_reg, src_b_imm, src_b_four} alu_src_b_e;
  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_e;
  typedef enum logic {adr_pc, adr_result} adr_src_e;
  typedef enum logic {pc_alu_result, pc_alu_out} pc_src_e;

  typedef struct packed {
    logic        ir_write;
    logic        pc_update;
    logic        reg_write;
    logic        mem_write;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    result_src_e result_src;
    adr_src_e    adr_src;
    pc_src_e     pc_src;
    logic        alu_sel_add;
  } ctrl_t;

  // program load, addr is a word index.
  typedef struct packed {
    logic  en;
    word_t addr;
    word_t data;
  } load_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    logic       rd_write;
    logic [4:0] rd;
    word_t      rd_value;
    logic       store;
    word_t      store_addr;
    word_t      store_data;
  } retire_t;

endpackage

`default_nettype wire

// File: tb_mc_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mc_core;

  localparam int mem_words   = 1024;
  localparam int idx_w       = $clog2(mem_words);
  localparam int prog_len    = 24;
  localparam int num_tests   = 6;
  localparam int data_base   = 128;
  localparam int data_words  = 16;
  // six cycles per program instruction out of reset, plus slack.
  localparam int cycle_limit = num_tests * prog_len * 6 + 200;

  logic               clk;
  logic               rst_n;
  riscv_pkg::load_t   load;
  riscv_pkg::retire_t retire;
  logic               halted;

  logic [31:0]        rng_state;
  int                 run_cycles = 0;
  int                 errors;
  int                 tests_ok;
  int                 model_count;
  riscv_pkg::word_t   prog [prog_len + 1];
  riscv_pkg::word_t   data_init [data_words];
  riscv_pkg::word_t   model_mem [mem_words];
  riscv_pkg::word_t   model_regs [32];
  riscv_pkg::retire_t exp_q [$];
  string              test_names [num_tests] = '{"rtype", "addi", "mem", "branch", "x0", "mixed"};

  mc_core #(.mem_words(mem_words)) mc_core_i (.clk(clk), .rst_n(rst_n), .load(load),
                                              .retire(retire), .halted(halted));

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      run_cycles = run_cycles + 1;
    end
    if (run_cycles > cycle_limit) begin
      $display("timeout: core still running after %0d cycles out of reset", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // swap halves since the low lcg bits are weak.
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  function automatic logic [4:0] pick_reg(input bit zbias);
    logic [31:0] r;
    r = next_rand();
    if (zbias && r[20]) begin
      return 5'd0;
    end
    return {2'b00, r[2:0]};
  endfunction

  // cls selects 0 r-type, 1 addi, 2 sw, 3 lw, 4 beq, else jal.
  function automatic riscv_pkg::word_t make_instr(input int cls, input int idx, input int kind);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          span;
    rd   = pick_reg(kind == 4);
    rs1  = pick_reg(kind == 4);
    rs2  = pick_reg(kind == 4);
    r    = next_rand();
    imm  = (kind == 3) ? {10'd0, r[1:0]} : r[11:0];
    // forward targets that never pass the closing zero word.
    span = (prog_len - idx < 4) ? prog_len - idx : 4;
    boff = 13'(4 * (1 + int'(r[15:12]) % span));
    joff = 21'(4 * (1 + int'(r[19:16]) % span));
    f3   = 3'b000;
    f7   = 7'd0;
    case (cls)
      0: begin
        case (int'(r[23:20]) % 6)
          1:       f7 = 7'h20;
          2:       f3 = 3'b111;
          3:       f3 = 3'b110;
          4:       f3 = 3'b100;
          5:       f3 = 3'b010;
          default: f3 = 3'b000;
        endcase
        return {f7, rs2, rs1, f3, rd, riscv_pkg::opc_op};
      end
      1: return {imm, rs1, 3'b000, rd, riscv_pkg::opc_op_imm};
      2: begin
        imm = 12'(data_base * 4 + 4 * int'(r[14:12]));
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], riscv_pkg::opc_store};
      end
      3: begin
        imm = 12'(data_base * 4 + 4 * int'(r[14:12]));
        return {imm, 5'd0, 3'b010, rd, riscv_pkg::opc_load};
      end
      4: begin
        if (kind == 3 && r[24]) begin
          rs2 = rs1;
        end
        return {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11],
                riscv_pkg::opc_branch};
      end
      default: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, riscv_pkg::opc_jal};
    endcase
  endfunction

  task automatic build_program(input int kind);
    logic [31:0] r;
    int          c;
    int          cls;
    for (int i = 0; i < prog_len; i++) begin
      r = next_rand();
      c = r % 10;
      case (kind)
        0:       cls = (i < 7) ? 1 : 0;
        1:       cls = 1;
        2:       cls = (i < 4) ? 1 : ((c < 4) ? 2 : 3);
        3:       cls = (i < 4) ? 1 : ((c < 4) ? 4 : ((c < 6) ? 5 : ((c < 8) ? 1 : 0)));
        4:       cls = (c < 5) ? 0 : 1;
        default: cls = r % 6;
      endcase
      prog[i] = make_instr(cls, i, kind);
    end
    prog[prog_len] = '0;
    for (int i = 0; i < data_words; i++) begin
      data_init[i] = next_rand();
    end
  endtask

  // instruction-set model that queues one expected retire record per instruction.
  task automatic run_model();
    riscv_pkg::word_t   pc;
    riscv_pkg::word_t   next_pc;
    riscv_pkg::word_t   w;
    riscv_pkg::word_t   a;
    riscv_pkg::word_t   b;
    riscv_pkg::word_t   v;
    riscv_pkg::word_t   addr;
    riscv_pkg::retire_t rec;
    logic [idx_w-1:0]   widx;
    bit                 running;
    bit                 wr;
    foreach (model_regs[i]) model_regs[i] = '0;
    for (int i = 0; i <= prog_len; i++) model_mem[i] = prog[i];
    for (int i = 0; i < data_words; i++) model_mem[data_base + i] = data_init[i];
    exp_q.delete();
    model_count = 0;
    pc = '0;
    running = 1'b1;
    while (running) begin
      widx = pc[idx_w+1:2];
      w    = model_mem[widx];
      a    = model_regs[w[19:15]];
      b    = model_regs[w[24:20]];
      rec  = '0;
      rec.valid = 1'b1;
      rec.pc    = pc;
      wr      = 1'b0;
      v       = '0;
      next_pc = pc + 32'd4;
      case (w[6:0])
        riscv_pkg::opc_op: begin
          wr = 1'b1;
          case (w[14:12])
            3'b000:  v = w[30] ? a - b : a + b;
            3'b010:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  v = a ^ b;
            3'b110:  v = a | b;
            default: v = a & b;
          endcase
        end
        riscv_pkg::opc_op_imm: begin
          wr = 1'b1;
          v  = a + {{20{w[31]}}, w[31:20]};
        end
        riscv_pkg::opc_load: begin
          wr   = 1'b1;
          addr = a + {{20{w[31]}}, w[31:20]};
          widx = addr[idx_w+1:2];
          v    = model_mem[widx];
        end
        riscv_pkg::opc_store: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          widx = addr[idx_w+1:2];
          model_mem[widx] = b;
          rec.store      = 1'b1;
          rec.store_addr = addr;
          rec.store_data = b;
        end
        riscv_pkg::opc_branch: begin
          if (a == b) begin
            next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        riscv_pkg::opc_jal: begin
          wr      = 1'b1;
          v       = pc + 32'd4;
          next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: running = 1'b0;
      endcase
      if (running) begin
        if (wr) begin
          rec.rd_write = 1'b1;
          rec.rd       = w[11:7];
          rec.rd_value = v;
          if (w[11:7] != 5'd0) model_regs[w[11:7]] = v;
        end
        exp_q.push_back(rec);
        model_count++;
        pc = next_pc;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_program();
    for (int i = 0; i <= prog_len; i++) begin
      load.en   = 1'b1;
      load.addr = i;
      load.data = prog[i];
      next_cycle();
    end
    for (int i = 0; i < data_words; i++) begin
      load.en   = 1'b1;
      load.addr = data_base + i;
      load.data = data_init[i];
      next_cycle();
    end
    load = '0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: retire.%s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_retire(input riscv_pkg::retire_t got, input riscv_pkg::retire_t exp);
    compare_field("pc", got.pc, exp.pc);
    compare_field("rd_write", 32'(got.rd_write), 32'(exp.rd_write));
    compare_field("rd", 32'(got.rd), 32'(exp.rd));
    compare_field("rd_value", got.rd_value, exp.rd_value);
    compare_field("store", 32'(got.store), 32'(exp.store));
    compare_field("store_addr", got.store_addr, exp.store_addr);
    compare_field("store_data", got.store_data, exp.store_data);
  endtask

  task automatic check_halt(input logic got_halted, input int retired, input int exp_count);
    if (got_halted !== 1'b1) begin
      $display("mismatch at %0t: halted got %b expected 1", $time, got_halted);
      errors++;
    end
    if (retired != exp_count) begin
      $display("mismatch at %0t: retired count got %0d expected %0d", $time, retired,
               exp_count);
      errors++;
    end
  endtask

  task automatic run_test(input int kind);
    int retired;
    int errs_before;
    errs_before = errors;
    build_program(kind);
    run_model();
    next_cycle();
    rst_n = 1'b0;
    load_program();
    retired = 0;
    while (!halted) begin
      @(negedge clk);
      if (retire.valid) begin
        if (exp_q.size() == 0) begin
          $display("retire record at %0t with no instruction left in the model", $time);
          errors++;
        end else begin
          check_retire(retire, exp_q.pop_front());
        end
        retired++;
      end
    end
    repeat (20) begin
      @(negedge clk);
      if (retire.valid) begin
        $display("retire pulse at %0t after the core halted", $time);
        errors++;
      end
    end
    // halt must still hold after the quiet window.
    check_halt(halted, retired, model_count);
    if (errors == errs_before) tests_ok++;
    $display("test %0d %s: %0d of %0d retired, %s", kind, test_names[kind], retired,
             model_count, (errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    rng_state = 32'h5cd6_398f;
    rst_n     = 1'b0;
    load      = '0;
    errors    = 0;
    tests_ok  = 0;
    for (int k = 0; k < num_tests; k++) begin
      run_test(k);
    end
    $display("tests passed %0d failed %0d", tests_ok, num_tests - tests_ok);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: unified_mem.sv
`timescale 1ns/1ns
`default_nettype none

module unified_mem #(
  parameter int mem_words = 1024
) (
  input  logic             clk,
  input  riscv_pkg::word_t addr,
  input  riscv_pkg::word_t wdata,
  input  logic             write,
  input  riscv_pkg::load_t load,
  output riscv_pkg::word_t rdata
);

  localparam int idx_w = $clog2(mem_words);

  riscv_pkg::word_t mem [mem_words];

  logic [idx_w-1:0] core_idx;
  logic [idx_w-1:0] load_idx;

  // byte address to word index, wrapped to the depth.
  assign core_idx = addr[idx_w+1:2];
  assign load_idx = load.addr[idx_w-1:0];

  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load_idx] <= load.data;
    end else if (write) begin
      mem[core_idx] <= wdata;
    end
  end

  assign rdata = mem[core_idx];

endmodule

`default_nettype wire
